// ==== vid2mem.f ====
+incdir+.
vid2mem_pkg.sv
vid2mem_if.sv
pixel_packer.sv
frame_addr_gen.sv
burst_writer.sv
vid2mem_top.sv
tb_vid2mem.sv

// ==== run_vid2mem.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_vid2mem \
   -f vid2mem.f -o sim_vid2mem &&
./obj_dir/sim_vid2mem | tee /dev/stderr | grep -q "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb_vid2mem.sv ====
`timescale 1ns/1ps
`include "vid2mem_consts.svh"

module tb_vid2mem import vid2mem_pkg::*; ();

   // pixels over all frames below
   localparam int TOTAL_PIX   = 1504;
   // 3 cycles per pixel covers gaps and slow drains at 4 ns per cycle
   localparam int WATCHDOG_NS = (TOTAL_PIX * 3 + 1000) * 4;

   logic        clk, reset, i_fs, i_de, i_enable, i_pingpong, i_data_req;
   logic        o_fbptr, o_addr_valid, o_data_valid, o_overflow;
   pixel_t      i_pix;
   addr_t       i_base_a, i_base_b, o_addr;
   word_t       o_data;
   // reference model state
   pixel_t      pix_q[$];
   word_t       exp_q[$];
   logic        m_ptr, m_active;
   addr_t       m_base;
   int          burst_n, beats_left, errors, beats, strobes;
   // 0 request low, 1 high, 2 random gaps
   int          req_mode;
   logic [31:0] rng_pix, rng_req;
   string       test_name;

   vid2mem_top i_vid2mem_top (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic report_mismatch(input string what, input word_t exp_v, input word_t act_v);
      errors++;
      $display("ERR %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%s failed: %s", test_name, what);
   endtask

   // pixel k at bit k*24 and word j taken from bit j*256
   task automatic pack_group();
      group_t grp;
      for (int k = 0; k < `VM_GROUP_PIX; k++) begin
         grp[k*`VM_PIX_W +: `VM_PIX_W] = pix_q[k];
      end
      for (int j = 0; j < `VM_GROUP_WORDS; j++) begin
         exp_q.push_back(grp[j*`VM_WORD_W +: `VM_WORD_W]);
      end
      pix_q.delete();
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, beats stopped arriving", WATCHDOG_NS);
      $display("=== FAIL ===");
      $finish;
   end

   // memory side request pattern
   initial begin
      forever begin
         @(posedge clk);
         #1;
         rng_req = xorshift(rng_req);
         case (req_mode)
            0:       i_data_req = 1'b0;
            1:       i_data_req = 1'b1;
            default: i_data_req = (rng_req[9:8] != 2'b00);
         endcase
      end
   end

   // ************************************************************************
   // protocol rules
   // ************************************************************************

   a_strobe_outside_burst: assert property (@(posedge clk) disable iff (reset)
      !(o_addr_valid && o_data_valid))
      else report_failure("address strobe while beats were pending");

   // waiting beat stays put until taken
   a_beat_held: assert property (@(posedge clk) disable iff (reset)
      (o_data_valid && !i_data_req && !i_fs) |=> (o_data_valid && $stable(o_data)))
      else report_failure("beat changed or vanished while waiting for a request");

   // ************************************************************************
   // model compare on outputs first and then on inputs of this edge
   // ************************************************************************

   always @(posedge clk) begin
      word_t exp_word;
      if (!reset) begin
         assert (o_fbptr == m_ptr) else report_mismatch("fbptr", m_ptr, o_fbptr);
         if (o_addr_valid) begin
            strobes++;
            assert (m_active) else report_failure("address strobe in a disabled frame");
            assert (beats_left == 0) else report_failure("strobe before 8 beats of the last");
            assert (o_addr == m_base + addr_t'(burst_n) * addr_t'(`VM_BURST_BYTES))
               else report_mismatch("address", m_base + burst_n * `VM_BURST_BYTES, o_addr);
            burst_n++;
            beats_left = `VM_BURST_WORDS;
         end
         if (o_data_valid && i_data_req) begin
            beats++;
            assert (beats_left > 0 && exp_q.size() > 0)
               else report_failure("extra beat with no expected word");
            if (beats_left > 0 && exp_q.size() > 0) begin
               exp_word = exp_q.pop_front();
               beats_left--;
               assert (o_data == exp_word) else report_mismatch("beat", exp_word, o_data);
            end
         end
         // frame start flushes everything not yet delivered
         if (i_fs) begin
            m_ptr      = i_pingpong ? ~m_ptr : 1'b0;
            m_base     = m_ptr ? i_base_b : i_base_a;
            m_active   = i_enable;
            burst_n    = 0;
            beats_left = 0;
            pix_q.delete();
            exp_q.delete();
         end else if (i_de && m_active) begin
            pix_q.push_back(i_pix);
            if (pix_q.size() == `VM_GROUP_PIX) begin
               pack_group();
            end
         end
      end
   end

   // ************************************************************************
   // stimulus
   // ************************************************************************

   task automatic frame_start(input logic en, input logic pp);
      @(posedge clk);
      #1;
      i_de       = 1'b0;
      i_fs       = 1'b1;
      i_enable   = en;
      i_pingpong = pp;
      @(posedge clk);
      #1;
      i_fs = 1'b0;
   endtask

   // about one cycle in four left idle when gaps is set
   task automatic send_pixels(input int n, input logic gaps);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge clk);
         #1;
         rng_pix = xorshift(rng_pix);
         i_de    = !(gaps && rng_pix[1:0] == 2'b00);
         i_pix   = rng_pix[31:8];
         if (i_de) begin
            sent++;
         end
      end
      @(posedge clk);
      #1;
      i_de = 1'b0;
   endtask

   // only a partial bank may stay behind
   task automatic wait_drained(input int left);
      repeat (8) @(negedge clk);
      while (exp_q.size() >= `VM_BURST_WORDS || o_data_valid) begin
         @(negedge clk);
      end
      assert (exp_q.size() == left) else report_mismatch("words left", left, exp_q.size());
   endtask

   initial begin
      {reset, i_fs, i_de, i_enable, i_pingpong, i_data_req} = 6'b100000;
      i_pix    = '0;
      i_base_a = 42'h2_1000_0000;
      i_base_b = 42'h3_8000_0000;
      {m_ptr, m_active, m_base} = '0;
      {burst_n, beats_left, errors, beats, strobes, req_mode} = '0;
      rng_pix   = 32'hbb87;
      rng_req   = xorshift(32'hbb87);
      test_name = "reset";
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      assert ({o_addr_valid, o_data_valid, o_overflow, o_fbptr} == 4'b0)
         else report_mismatch("controls", 0, {o_addr_valid, o_data_valid, o_overflow, o_fbptr});

      // pointer 0 to 1, buffer b, random pixel and request gaps
      test_name = "pingpong_b";
      req_mode  = 2;
      frame_start(1'b1, 1'b1);
      send_pixels(256, 1'b1);
      wait_drained(0);

      // back to buffer a, partial group at the end
      test_name = "pingpong_a";
      req_mode  = 1;
      frame_start(1'b1, 1'b1);
      send_pixels(266, 1'b0);
      wait_drained(0);

      test_name = "single_buffer";
      req_mode  = 2;
      frame_start(1'b1, 1'b0);
      send_pixels(128, 1'b0);
      wait_drained(4);

      // fs lands mid-group and mid-burst
      test_name = "restart";
      @(negedge clk);
      req_mode = 0;
      frame_start(1'b1, 1'b1);
      send_pixels(150, 1'b0);
      repeat (4) @(negedge clk);
      req_mode = 1;
      repeat (3) @(negedge clk);
      req_mode = 0;
      assert (o_data_valid) else report_failure("no burst in progress at the restart");
      test_name = "after_restart";
      @(posedge clk);
      #1;
      i_base_a  = 42'h0_4000_0000;
      frame_start(1'b1, 1'b0);
      @(negedge clk);
      req_mode = 2;
      send_pixels(256, 1'b1);
      wait_drained(0);

      // 18 words against two 8-word banks that never drain
      test_name = "overflow";
      @(negedge clk);
      req_mode = 0;
      frame_start(1'b1, 1'b1);
      send_pixels(192, 1'b0);
      repeat (12) @(negedge clk);
      assert (o_overflow) else report_mismatch("overflow set", 1, o_overflow);

      test_name = "disabled";
      frame_start(1'b0, 1'b1);
      @(negedge clk);
      assert (!o_overflow) else report_mismatch("overflow clear", 0, o_overflow);
      req_mode = 1;
      send_pixels(256, 1'b0);
      repeat (30) @(negedge clk);

      $display("strobes %0d beats %0d errors %0d", strobes, beats, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== vid2mem_top.sv ====
`timescale 1ns/1ps

module vid2mem_top import vid2mem_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   // video side
   input  logic   i_fs,
   input  logic   i_de,
   input  pixel_t i_pix,
   // frame control
   input  logic   i_enable,
   input  logic   i_pingpong,
   input  addr_t  i_base_a,
   input  addr_t  i_base_b,
   output logic   o_fbptr,
   // memory side
   output logic   o_addr_valid,
   output addr_t  o_addr,
   output logic   o_data_valid,
   output word_t  o_data,
   input  logic   i_data_req,
   output logic   o_overflow
);

   // packer to burst buffer
   word_stream_if word_bus ();
   // address generator to burst buffer
   frame_addr_if  frame_bus ();

   // pixels only counted in an enabled frame
   pixel_packer i_pixel_packer (
      .clk     (clk),
      .reset   (reset),
      .i_fs    (i_fs),
      .i_en    (frame_bus.active),
      .i_de    (i_de),
      .i_pix   (i_pix),
      .o_words (word_bus.sender)
   );

   frame_addr_gen i_frame_addr_gen (
      .clk        (clk),
      .reset      (reset),
      .i_fs       (i_fs),
      .i_enable   (i_enable),
      .i_pingpong (i_pingpong),
      .i_base_a   (i_base_a),
      .i_base_b   (i_base_b),
      .o_fbptr    (o_fbptr),
      .o_frame    (frame_bus.provider)
   );

   burst_writer i_burst_writer (
      .clk          (clk),
      .reset        (reset),
      .i_fs         (i_fs),
      .i_words      (word_bus.receiver),
      .i_frame      (frame_bus.user),
      .o_addr_valid (o_addr_valid),
      .o_addr       (o_addr),
      .o_data_valid (o_data_valid),
      .o_data       (o_data),
      .i_data_req   (i_data_req),
      .o_overflow   (o_overflow)
   );

endmodule

// ==== burst_writer.sv ====
`timescale 1ns/1ps
`include "vid2mem_consts.svh"

module burst_writer import vid2mem_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            i_fs,
   word_stream_if.receiver i_words,
   frame_addr_if.user      i_frame,
   output logic            o_addr_valid,
   output addr_t           o_addr,
   output logic            o_data_valid,
   output word_t           o_data,
   input  logic            i_data_req,
   output logic            o_overflow
);

   localparam int CNT_W = $clog2(`VM_BURST_WORDS);

   // two banks back to back, index {bank, beat}
   word_t            r_mem [0:2*`VM_BURST_WORDS-1];
   bank_sel_t        r_wr_bank;
   logic [CNT_W-1:0] r_wr_cnt;
   // per bank, full until its burst is drained
   logic [1:0]       r_full;
   bank_sel_t        r_rd_bank;
   logic [CNT_W-1:0] r_rd_cnt;
   logic             r_busy;
   logic             r_done;
   logic             r_ovf;
   // show-ahead beat register
   word_t            r_data;
   logic             w_accept;
   logic             w_drop;
   logic             w_wr_last;
   logic             w_strobe;
   logic             w_beat;
   logic             w_rd_last;
   logic [CNT_W-1:0] w_rd_next;

   // write bank still full means both banks are full
   assign w_accept  = i_words.valid && !r_full[r_wr_bank];
   assign w_drop    = i_words.valid && r_full[r_wr_bank];
   assign w_wr_last = w_accept && (r_wr_cnt == CNT_W'(`VM_BURST_WORDS - 1));

   // no strobe while draining or in the burst_done cycle,
   // the address steps on that cycle
   assign w_strobe  = !r_busy && !r_done && r_full[r_rd_bank] && !i_fs;
   assign w_beat    = r_busy && i_data_req;
   assign w_rd_last = w_beat && (r_rd_cnt == CNT_W'(`VM_BURST_WORDS - 1));
   assign w_rd_next = r_rd_cnt + 1'b1;

   // ************************************************************************
   // bank fill
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (w_accept) begin
         r_mem[{r_wr_bank, r_wr_cnt}] <= i_words.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         r_wr_bank <= 1'b0;
         r_wr_cnt  <= '0;
      end else if (w_accept) begin
         // counter wraps to 0 as the bank completes
         r_wr_cnt <= r_wr_cnt + 1'b1;
         if (w_wr_last) begin
            r_wr_bank <= ~r_wr_bank;
         end
      end
   end

   // fill and drain never touch the same bank in one cycle
   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         r_full <= '0;
      end else begin
         if (w_wr_last) begin
            r_full[r_wr_bank] <= 1'b1;
         end
         if (w_rd_last) begin
            r_full[r_rd_bank] <= 1'b0;
         end
      end
   end

   // ************************************************************************
   // bank drain
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         r_busy    <= 1'b0;
         r_done    <= 1'b0;
         r_rd_bank <= 1'b0;
         r_rd_cnt  <= '0;
      end else begin
         r_done <= w_rd_last;
         if (w_strobe) begin
            r_busy   <= 1'b1;
            r_rd_cnt <= '0;
         end else if (w_beat) begin
            r_rd_cnt <= w_rd_next;
            if (w_rd_last) begin
               r_busy    <= 1'b0;
               r_rd_bank <= ~r_rd_bank;
            end
         end
      end
   end

   // first beat preloaded at the strobe, next one after each transfer
   always_ff @(posedge clk) begin
      if (w_strobe) begin
         r_data <= r_mem[{r_rd_bank, {CNT_W{1'b0}}}];
      end else if (w_beat && !w_rd_last) begin
         r_data <= r_mem[{r_rd_bank, w_rd_next}];
      end
   end

   // sticky until next frame start
   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         r_ovf <= 1'b0;
      end else if (w_drop) begin
         r_ovf <= 1'b1;
      end
   end

   assign o_addr_valid       = w_strobe;
   assign o_addr             = i_frame.addr;
   assign o_data_valid       = r_busy;
   assign o_data             = r_data;
   assign o_overflow         = r_ovf;
   assign i_frame.burst_done = r_done;

endmodule

// ==== frame_addr_gen.sv ====
`timescale 1ns/1ps
`include "vid2mem_consts.svh"

module frame_addr_gen import vid2mem_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            i_fs,
   input  logic            i_enable,
   input  logic            i_pingpong,
   input  addr_t           i_base_a,
   input  addr_t           i_base_b,
   output logic            o_fbptr,
   frame_addr_if.provider  o_frame
);

   // 0 writes frame buffer a, 1 writes b
   logic  r_ptr;
   // enable captured at frame start
   logic  r_active;
   addr_t r_addr;
   logic  w_ptr_nxt;

   // toggle only in ping-pong mode, else stay on buffer a
   assign w_ptr_nxt = i_pingpong ? ~r_ptr : 1'b0;

   // ************************************************************************
   // frame control, sampled only at fs
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         r_ptr    <= 1'b0;
         r_active <= 1'b0;
      end else if (i_fs) begin
         r_ptr    <= w_ptr_nxt;
         r_active <= i_enable;
      end
   end

   // base reload wins over a burst step in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         r_addr <= '0;
      end else if (i_fs) begin
         // base follows the new pointer value
         r_addr <= w_ptr_nxt ? i_base_b : i_base_a;
      end else if (o_frame.burst_done) begin
         r_addr <= r_addr + addr_t'(`VM_BURST_BYTES);
      end
   end

   assign o_fbptr        = r_ptr;
   assign o_frame.addr   = r_addr;
   assign o_frame.active = r_active;

endmodule

// ==== pixel_packer.sv ====
`timescale 1ns/1ps
`include "vid2mem_consts.svh"

module pixel_packer import vid2mem_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          i_fs,
   input  logic          i_en,
   input  logic          i_de,
   input  pixel_t        i_pix,
   word_stream_if.sender o_words
);

   localparam int CNT_W = $clog2(`VM_GROUP_PIX);

   // group buffer, one slot per pixel
   pixel_t                     r_ibuf [0:`VM_GROUP_PIX-1];
   logic [CNT_W-1:0]           r_cnt;
   // one-hot word strobe shifter
   logic [`VM_GROUP_WORDS-1:0] r_emit;
   // completed group, shifted down one word per strobe
   group_t                     r_stage;
   group_t                     w_group;
   logic                       w_wr;
   logic                       w_last;

   // pixel taken only in an enabled frame, never on the fs cycle
   assign w_wr   = i_de && i_en && !i_fs;
   assign w_last = w_wr && (r_cnt == CNT_W'(`VM_GROUP_PIX - 1));

   // ************************************************************************
   // fill side
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (w_wr) begin
         r_ibuf[r_cnt] <= i_pix;
      end
   end

   // wraps to 0 after the 32nd pixel
   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         r_cnt <= '0;
      end else if (w_wr) begin
         r_cnt <= r_cnt + 1'b1;
      end
   end

   // group view with the incoming pixel bypassed into its slot
   // so the copy can happen on the same edge as the last write
   always_comb begin
      for (int k = 0; k < `VM_GROUP_PIX; k++) begin
         if (w_wr && (r_cnt == CNT_W'(k))) begin
            w_group[k*`VM_PIX_W +: `VM_PIX_W] = i_pix;
         end else begin
            w_group[k*`VM_PIX_W +: `VM_PIX_W] = r_ibuf[k];
         end
      end
   end

   // ************************************************************************
   // word strobes, t+1 .. t+3 after the last pixel
   // ************************************************************************

   always_ff @(posedge clk) begin
      if (w_last) begin
         r_stage <= w_group;
      end else if (|r_emit) begin
         // next word moves down to bit 0
         r_stage <= r_stage >> `VM_WORD_W;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || i_fs) begin
         // staged words of the old frame are dropped
         r_emit <= '0;
      end else if (w_last) begin
         r_emit <= `VM_GROUP_WORDS'(1);
      end else begin
         r_emit <= r_emit << 1;
      end
   end

   assign o_words.valid = |r_emit;
   assign o_words.data  = r_stage[`VM_WORD_W-1:0];

endmodule

// ==== vid2mem_if.sv ====
`timescale 1ns/1ps

// ***************************************************************************
// packed word stream, packer to burst buffer
// ***************************************************************************

interface word_stream_if import vid2mem_pkg::*; ();

   // one word per valid cycle, no back-pressure
   logic  valid;
   word_t data;

   modport sender (
      output valid,
      output data
   );

   modport receiver (
      input valid,
      input data
   );

endinterface

// ***************************************************************************
// frame address contract, address generator to burst buffer
// ***************************************************************************

interface frame_addr_if import vid2mem_pkg::*; ();

   // address of the next burst
   addr_t addr;
   // pulse after the last beat of a burst
   logic  burst_done;
   // frame enabled at its start
   logic  active;

   modport provider (
      output addr,
      output active,
      input  burst_done
   );

   modport user (
      input  addr,
      input  active,
      output burst_done
   );

endinterface

// ==== vid2mem_pkg.sv ====
// ***************************************************************************
// shared types for the write engine
// ***************************************************************************

package vid2mem_pkg;

`include "vid2mem_consts.svh"

   // one incoming pixel
   typedef logic [`VM_PIX_W-1:0] pixel_t;

   // one beat on the memory data bus
   typedef logic [`VM_WORD_W-1:0] word_t;

   // a full group of pixels, pixel k at bit k*24
   typedef logic [`VM_GROUP_PIX*`VM_PIX_W-1:0] group_t;

   // byte address into memory
   typedef logic [`VM_ADDR_W-1:0] addr_t;

   // which of the two burst banks
   typedef logic bank_sel_t;

endpackage

// ==== vid2mem_consts.svh ====
`ifndef VID2MEM_CONSTS_SVH
`define VID2MEM_CONSTS_SVH

// ***************************************************************************
// video to memory write engine sizes
// ***************************************************************************

// one rgb pixel
`define VM_PIX_W        24

// memory data bus width
`define VM_WORD_W       256

// pixels collected before packing
`define VM_GROUP_PIX    32

// 32 x 24 = 768 = 3 x 256
`define VM_GROUP_WORDS  3

// beats per address strobe
`define VM_BURST_WORDS  8

// memory address width
`define VM_ADDR_W       42

// address step per burst, 8 beats of 32 bytes
`define VM_BURST_BYTES  256

`endif
